// ==== udp_rx_params.svh ====
/* udp receiver parameters */

`ifndef UDP_RX_PARAMS_SVH
`define UDP_RX_PARAMS_SVH

// payload datapath width in bits
`define UDP_DATA_W 64

// one byte enable per payload byte
`define UDP_KEEP_W 8

// fixed udp header size in bytes
`define UDP_HDR_BYTES 8

`endif

// ==== udp_rx_pkg.sv ====
/* udp receiver types */

`default_nettype none

package udp_rx_pkg;

    `include "udp_rx_params.svh"

    typedef logic [`UDP_DATA_W-1:0] word_t;
    typedef logic [`UDP_KEEP_W-1:0] keep_t;
    typedef logic [31:0] ip_addr_t;

    // ports, length and checksum share one width
    typedef logic [15:0] port_t;

    // first field sits in the msbs, matching wire order after byte swap
    typedef struct packed {
        port_t source_port;
        port_t dest_port;
        port_t length;
        port_t checksum;
    } udp_hdr_t;

endpackage

`default_nettype wire

// ==== axis_beat_if.sv ====
/* payload beat stream */

`timescale 1ns/1ps
`default_nettype none

interface axis_beat_if;
    import udp_rx_pkg::*;

    word_t tdata;
    keep_t tkeep;
    logic  tvalid;
    logic  tready;
    logic  tlast;
    logic  tuser;

    // parser side
    modport src (output tdata, tkeep, tvalid, tlast, tuser, input tready);

    // skid buffer side
    modport dst (input tdata, tkeep, tvalid, tlast, tuser, output tready);

endinterface

`default_nettype wire

// ==== udp_rx_parser.sv ====
/* udp frame parser */

`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_params.svh"

module udp_rx_parser (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  ip_hdr_valid,
    output logic                 ip_hdr_ready,
    input  udp_rx_pkg::ip_addr_t ip_source_ip,
    input  udp_rx_pkg::ip_addr_t ip_dest_ip,
    input  udp_rx_pkg::word_t    ip_payload_tdata,
    input  udp_rx_pkg::keep_t    ip_payload_tkeep,
    input  wire                  ip_payload_tvalid,
    output logic                 ip_payload_tready,
    input  wire                  ip_payload_tlast,
    input  wire                  ip_payload_tuser,
    output logic                 udp_hdr_valid,
    input  wire                  udp_hdr_ready,
    output udp_rx_pkg::ip_addr_t udp_source_ip,
    output udp_rx_pkg::ip_addr_t udp_dest_ip,
    output udp_rx_pkg::udp_hdr_t udp_hdr,
    output logic                 busy,
    output logic                 error_header_early_termination,
    output logic                 error_payload_early_termination,
    axis_beat_if.src             beat
);
    import udp_rx_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_PAYLOAD, ST_DRAIN} state_t;

    state_t   state, state_next;
    port_t    remain, remain_next;
    logic     hdr_valid_next;
    logic     store_ip_hdr;
    logic     store_udp_hdr;
    logic     last_beat;
    logic     early_end;
    logic     err_hdr_next;
    logic     err_pay_next;
    port_t    in_count;
    udp_hdr_t hdr_word;

    // wire order is big-endian, lane 0 carries the most significant byte
    function automatic word_t byte_swap(input word_t w);
        word_t s;
        for (int i = 0; i < `UDP_KEEP_W; i++) begin
            s[8*i +: 8] = w[`UDP_DATA_W - 8*(i+1) +: 8];
        end
        return s;
    endfunction

    function automatic port_t keep_count(input keep_t k);
        port_t c;
        c = '0;
        for (int i = 0; i < `UDP_KEEP_W; i++) begin
            c = c + port_t'(k[i]);
        end
        return c;
    endfunction

    // low n byte lanes enabled
    function automatic keep_t keep_mask(input port_t n);
        keep_t m;
        m = '0;
        for (int i = 0; i < `UDP_KEEP_W; i++) begin
            if (port_t'(i) < n) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    assign hdr_word = udp_hdr_t'(byte_swap(ip_payload_tdata));
    assign in_count = keep_count(ip_payload_tkeep);

    // beat that reaches length minus header, or ends the frame too soon
    assign last_beat = (state == ST_PAYLOAD) && (in_count >= remain);
    assign early_end = (state == ST_PAYLOAD) && !last_beat && ip_payload_tlast;

    assign beat.tvalid = (state == ST_PAYLOAD) && ip_payload_tvalid;
    assign beat.tdata  = ip_payload_tdata;
    assign beat.tkeep  = ip_payload_tkeep & keep_mask(remain);
    assign beat.tlast  = ip_payload_tlast | last_beat;
    assign beat.tuser  = ip_payload_tuser | early_end;

    always_comb begin
        case (state)
            ST_PAYLOAD: ip_payload_tready = beat.tready;
            ST_HEADER,
            ST_DRAIN:   ip_payload_tready = 1'b1;
            default:    ip_payload_tready = 1'b0;
        endcase
    end

    always_comb begin
        state_next     = state;
        remain_next    = remain;
        hdr_valid_next = udp_hdr_valid & ~udp_hdr_ready;
        store_ip_hdr   = 1'b0;
        store_udp_hdr  = 1'b0;
        err_hdr_next   = 1'b0;
        err_pay_next   = 1'b0;

        case (state)
            ST_IDLE: begin
                if (ip_hdr_ready && ip_hdr_valid) begin
                    store_ip_hdr = 1'b1;
                    state_next   = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (ip_payload_tvalid) begin
                    if (ip_payload_tlast) begin
                        err_hdr_next = 1'b1;
                        state_next   = ST_IDLE;
                    end else begin
                        store_udp_hdr  = 1'b1;
                        hdr_valid_next = 1'b1;
                        // short or zero length leaves nothing to forward
                        if (hdr_word.length > port_t'(`UDP_HDR_BYTES)) begin
                            remain_next = hdr_word.length - port_t'(`UDP_HDR_BYTES);
                            state_next  = ST_PAYLOAD;
                        end else begin
                            remain_next = '0;
                            state_next  = ST_DRAIN;
                        end
                    end
                end
            end
            ST_PAYLOAD: begin
                if (ip_payload_tvalid && beat.tready) begin
                    if (last_beat) begin
                        remain_next = '0;
                        state_next  = ip_payload_tlast ? ST_IDLE : ST_DRAIN;
                    end else begin
                        remain_next = remain - in_count;
                        if (ip_payload_tlast) begin
                            err_pay_next = 1'b1;
                            state_next   = ST_IDLE;
                        end
                    end
                end
            end
            default: begin
                // discard until the input frame ends
                if (ip_payload_tvalid && ip_payload_tlast) begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                           <= ST_IDLE;
            remain                          <= '0;
            ip_hdr_ready                    <= 1'b0;
            udp_hdr_valid                   <= 1'b0;
            busy                            <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            remain                          <= remain_next;
            ip_hdr_ready                    <= (state_next == ST_IDLE) && !hdr_valid_next;
            udp_hdr_valid                   <= hdr_valid_next;
            busy                            <= state_next != ST_IDLE;
            error_header_early_termination  <= err_hdr_next;
            error_payload_early_termination <= err_pay_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_ip_hdr) begin
            udp_source_ip <= ip_source_ip;
            udp_dest_ip   <= ip_dest_ip;
        end
        if (store_udp_hdr) begin
            udp_hdr <= hdr_word;
        end
    end

endmodule

`default_nettype wire

// ==== udp_skid_buffer.sv ====
/* payload skid buffer */

`timescale 1ns/1ps
`default_nettype none

module udp_skid_buffer (
    input  wire               clk,
    input  wire               rst,
    axis_beat_if.dst          in,
    output udp_rx_pkg::word_t udp_payload_tdata,
    output udp_rx_pkg::keep_t udp_payload_tkeep,
    output logic              udp_payload_tvalid,
    input  wire               udp_payload_tready,
    output logic              udp_payload_tlast,
    output logic              udp_payload_tuser
);
    import udp_rx_pkg::*;

    word_t temp_tdata;
    keep_t temp_tkeep;
    logic  temp_tlast;
    logic  temp_tuser;
    logic  temp_valid, temp_valid_next;
    logic  out_valid_next;
    logic  store_in_out, store_in_temp, store_temp_out;
    logic  ready_early;

    // ready for the next cycle drops once a stall would fill temp
    assign ready_early = udp_payload_tready ||
                         (!temp_valid && (!udp_payload_tvalid || !in.tvalid));

    always_comb begin
        out_valid_next  = udp_payload_tvalid;
        temp_valid_next = temp_valid;
        store_in_out    = 1'b0;
        store_in_temp   = 1'b0;
        store_temp_out  = 1'b0;

        if (in.tready) begin
            if (udp_payload_tready || !udp_payload_tvalid) begin
                out_valid_next = in.tvalid;
                store_in_out   = 1'b1;
            end else begin
                temp_valid_next = in.tvalid;
                store_in_temp   = 1'b1;
            end
        end else if (udp_payload_tready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_out  = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            udp_payload_tvalid <= 1'b0;
            temp_valid         <= 1'b0;
            in.tready          <= 1'b1;
        end else begin
            udp_payload_tvalid <= out_valid_next;
            temp_valid         <= temp_valid_next;
            in.tready          <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_out) begin
            udp_payload_tdata <= in.tdata;
            udp_payload_tkeep <= in.tkeep;
            udp_payload_tlast <= in.tlast;
            udp_payload_tuser <= in.tuser;
        end else if (store_temp_out) begin
            udp_payload_tdata <= temp_tdata;
            udp_payload_tkeep <= temp_tkeep;
            udp_payload_tlast <= temp_tlast;
            udp_payload_tuser <= temp_tuser;
        end
        if (store_in_temp) begin
            temp_tdata <= in.tdata;
            temp_tkeep <= in.tkeep;
            temp_tlast <= in.tlast;
            temp_tuser <= in.tuser;
        end
    end

endmodule

`default_nettype wire

// ==== udp_ip_rx.sv ====
/* udp receiver, ip frame in, udp frame out */

`timescale 1ns/1ps
`default_nettype none

module udp_ip_rx (
    input  wire                  clk,
    input  wire                  rst,

    // ip frame in
    input  wire                  ip_hdr_valid,
    output wire                  ip_hdr_ready,
    input  udp_rx_pkg::ip_addr_t ip_source_ip,
    input  udp_rx_pkg::ip_addr_t ip_dest_ip,
    input  udp_rx_pkg::word_t    ip_payload_tdata,
    input  udp_rx_pkg::keep_t    ip_payload_tkeep,
    input  wire                  ip_payload_tvalid,
    output wire                  ip_payload_tready,
    input  wire                  ip_payload_tlast,
    input  wire                  ip_payload_tuser,

    // udp frame out
    output wire                  udp_hdr_valid,
    input  wire                  udp_hdr_ready,
    output udp_rx_pkg::ip_addr_t udp_source_ip,
    output udp_rx_pkg::ip_addr_t udp_dest_ip,
    output udp_rx_pkg::port_t    udp_source_port,
    output udp_rx_pkg::port_t    udp_dest_port,
    output udp_rx_pkg::port_t    udp_length,
    output udp_rx_pkg::port_t    udp_checksum,
    output udp_rx_pkg::word_t    udp_payload_tdata,
    output udp_rx_pkg::keep_t    udp_payload_tkeep,
    output wire                  udp_payload_tvalid,
    input  wire                  udp_payload_tready,
    output wire                  udp_payload_tlast,
    output wire                  udp_payload_tuser,

    // status
    output wire                  busy,
    output wire                  error_header_early_termination,
    output wire                  error_payload_early_termination
);
    import udp_rx_pkg::*;

    udp_hdr_t udp_hdr;

    axis_beat_if beat ();

    udp_rx_parser u_parser (
        .clk                             (clk),
        .rst                             (rst),
        .ip_hdr_valid                    (ip_hdr_valid),
        .ip_hdr_ready                    (ip_hdr_ready),
        .ip_source_ip                    (ip_source_ip),
        .ip_dest_ip                      (ip_dest_ip),
        .ip_payload_tdata                (ip_payload_tdata),
        .ip_payload_tkeep                (ip_payload_tkeep),
        .ip_payload_tvalid               (ip_payload_tvalid),
        .ip_payload_tready               (ip_payload_tready),
        .ip_payload_tlast                (ip_payload_tlast),
        .ip_payload_tuser                (ip_payload_tuser),
        .udp_hdr_valid                   (udp_hdr_valid),
        .udp_hdr_ready                   (udp_hdr_ready),
        .udp_source_ip                   (udp_source_ip),
        .udp_dest_ip                     (udp_dest_ip),
        .udp_hdr                         (udp_hdr),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination),
        .beat                            (beat.src)
    );

    udp_skid_buffer u_skid (
        .clk                (clk),
        .rst                (rst),
        .in                 (beat.dst),
        .udp_payload_tdata  (udp_payload_tdata),
        .udp_payload_tkeep  (udp_payload_tkeep),
        .udp_payload_tvalid (udp_payload_tvalid),
        .udp_payload_tready (udp_payload_tready),
        .udp_payload_tlast  (udp_payload_tlast),
        .udp_payload_tuser  (udp_payload_tuser)
    );

    // header fields out as separate ports
    assign udp_source_port = udp_hdr.source_port;
    assign udp_dest_port   = udp_hdr.dest_port;
    assign udp_length      = udp_hdr.length;
    assign udp_checksum    = udp_hdr.checksum;

endmodule

`default_nettype wire

// ==== tb_udp_ip_rx.sv ====
/* udp receiver testbench */

`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_params.svh"

module tb_udp_ip_rx;
    import udp_rx_pkg::*;

    localparam int TIMEOUT = 400;

    logic     clk;
    logic     rst;
    logic     ip_hdr_valid;
    wire      ip_hdr_ready;
    ip_addr_t ip_source_ip;
    ip_addr_t ip_dest_ip;
    word_t    ip_payload_tdata;
    keep_t    ip_payload_tkeep;
    logic     ip_payload_tvalid;
    wire      ip_payload_tready;
    logic     ip_payload_tlast;
    logic     ip_payload_tuser;
    wire      udp_hdr_valid;
    logic     udp_hdr_ready;
    ip_addr_t udp_source_ip;
    ip_addr_t udp_dest_ip;
    port_t    udp_source_port;
    port_t    udp_dest_port;
    port_t    udp_length;
    port_t    udp_checksum;
    word_t    udp_payload_tdata;
    keep_t    udp_payload_tkeep;
    wire      udp_payload_tvalid;
    logic     udp_payload_tready;
    wire      udp_payload_tlast;
    wire      udp_payload_tuser;
    wire      busy;
    wire      error_header_early_termination;
    wire      error_payload_early_termination;

    bit       bp_on;
    int       test_count;
    int       check_count;
    int       error_count;
    int       test_errors;

    // collected dut output
    word_t    got_data[$];
    keep_t    got_keep[$];
    bit       got_last[$];
    bit       got_user[$];
    int       hdr_count;
    int       err_hdr_count;
    int       err_pay_count;
    ip_addr_t got_src_ip;
    ip_addr_t got_dst_ip;
    port_t    got_sport;
    port_t    got_dport;
    port_t    got_len;
    port_t    got_csum;

    // current frame and its expected output
    logic [7:0] pay_bytes[$];
    logic [7:0] exp_bytes[$];
    keep_t      exp_keep[$];
    bit         exp_last[$];
    bit         exp_user[$];
    bit         exp_early;

    udp_ip_rx UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // outputs are stable at the falling edge, a transfer seen here completes on the next rise
    always @(negedge clk) begin
        if (!rst) begin
            if (udp_payload_tvalid && udp_payload_tready) begin
                got_data.push_back(udp_payload_tdata);
                got_keep.push_back(udp_payload_tkeep);
                got_last.push_back(udp_payload_tlast);
                got_user.push_back(udp_payload_tuser);
            end
            if (udp_hdr_valid && udp_hdr_ready) begin
                hdr_count  = hdr_count + 1;
                got_src_ip = udp_source_ip;
                got_dst_ip = udp_dest_ip;
                got_sport  = udp_source_port;
                got_dport  = udp_dest_port;
                got_len    = udp_length;
                got_csum   = udp_checksum;
            end
            if (error_header_early_termination) begin
                err_hdr_count = err_hdr_count + 1;
            end
            if (error_payload_early_termination) begin
                err_pay_count = err_pay_count + 1;
            end
        end
    end

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (bp_on) begin
                udp_payload_tready <= 1'($urandom);
                udp_hdr_ready      <= 1'($urandom);
            end else begin
                udp_payload_tready <= 1'b1;
                udp_hdr_ready      <= 1'b1;
            end
        end
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count,
                 error_count + 1);
        $display("Verification failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_count++;
    endtask

    function automatic keep_t lane_mask(input int n);
        keep_t m;
        m = '0;
        for (int i = 0; i < n; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    // big-endian fields, lane 0 is the high byte of the source port
    function automatic word_t header_word(input port_t sport, input port_t dport,
                                          input port_t len, input port_t csum);
        return {csum[7:0], csum[15:8], len[7:0], len[15:8],
                dport[7:0], dport[15:8], sport[7:0], sport[15:8]};
    endfunction

    task automatic put_ip_header(input ip_addr_t src, input ip_addr_t dst);
        int waited;
        bit taken;
        ip_source_ip <= src;
        ip_dest_ip   <= dst;
        ip_hdr_valid <= 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(negedge clk);
            taken = ip_hdr_ready;
            @(posedge clk);
            waited++;
        end
        ip_hdr_valid <= 1'b0;
        if (!taken) begin
            stop_on_timeout("ip_hdr_ready");
        end
    endtask

    task automatic put_beat(input word_t data, input keep_t keep, input bit last);
        int waited;
        bit taken;
        ip_payload_tdata  <= data;
        ip_payload_tkeep  <= keep;
        ip_payload_tlast  <= last;
        ip_payload_tvalid <= 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(negedge clk);
            taken = ip_payload_tready;
            @(posedge clk);
            waited++;
        end
        if (!taken) begin
            stop_on_timeout("ip_payload_tready");
        end
    endtask

    // ip header, then the udp header word, then the payload bytes from lane 0 up
    task automatic send_frame(input ip_addr_t src, input ip_addr_t dst, input port_t sport,
                              input port_t dport, input port_t len, input port_t csum,
                              input bit hdr_last);
        int    nbeats;
        int    in_b;
        word_t w;
        put_ip_header(src, dst);
        put_beat(header_word(sport, dport, len, csum), '1, hdr_last);
        nbeats = hdr_last ? 0 : (pay_bytes.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            in_b = (pay_bytes.size() - 8*b > 8) ? 8 : pay_bytes.size() - 8*b;
            w    = {$urandom, $urandom};
            for (int i = 0; i < in_b; i++) begin
                w[8*i +: 8] = pay_bytes[8*b + i];
            end
            put_beat(w, lane_mask(in_b), b == nbeats - 1);
        end
        ip_payload_tvalid <= 1'b0;
        ip_payload_tlast  <= 1'b0;
    endtask

    // bytes past length minus header are dropped, a short frame flags its last beat
    task automatic build_model(input port_t len, input bit hdr_last);
        int n;
        int fwd;
        int nbeats;
        int in_b;
        int take;
        exp_bytes.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_user.delete();
        n      = pay_bytes.size();
        fwd    = (int'(len) > `UDP_HDR_BYTES) ? int'(len) - `UDP_HDR_BYTES : 0;
        nbeats = hdr_last ? 0 : (n + 7) / 8;
        for (int b = 0; b < nbeats && 8*b < fwd; b++) begin
            in_b = (n - 8*b > 8) ? 8 : n - 8*b;
            take = (fwd - 8*b < in_b) ? fwd - 8*b : in_b;
            exp_keep.push_back(lane_mask(take));
            exp_last.push_back(8*b + in_b >= fwd || b == nbeats - 1);
            exp_user.push_back(8*b + in_b < fwd && b == nbeats - 1);
            for (int i = 0; i < take; i++) begin
                exp_bytes.push_back(pay_bytes[8*b + i]);
            end
        end
        exp_early = !hdr_last && n < fwd;
    endtask

    // frame is out once nothing is pending on any output
    task automatic wait_idle(output bit busy_at_end);
        int waited;
        bit idle;
        waited = 0;
        idle   = 1'b0;
        busy_at_end = 1'b1;
        while (!idle && waited < TIMEOUT) begin
            @(negedge clk);
            idle = !udp_payload_tvalid && !udp_hdr_valid &&
                   !error_header_early_termination && !error_payload_early_termination;
            busy_at_end = busy;
            waited++;
        end
        if (!idle) begin
            stop_on_timeout("the udp frame to leave the DUT");
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic run_frame(input port_t len, input int nbytes, input bit hdr_last);
        ip_addr_t src;
        ip_addr_t dst;
        port_t    sport;
        port_t    dport;
        port_t    csum;
        int       base_beat;
        int       base_hdr;
        int       base_err_hdr;
        int       base_err_pay;
        int       k;
        bit       busy_at_end;
        src   = $urandom;
        dst   = $urandom;
        sport = 16'($urandom);
        dport = 16'($urandom);
        csum  = 16'($urandom);
        pay_bytes.delete();
        for (int i = 0; i < nbytes; i++) begin
            pay_bytes.push_back(8'($urandom));
        end
        build_model(len, hdr_last);
        base_beat    = got_data.size();
        base_hdr     = hdr_count;
        base_err_hdr = err_hdr_count;
        base_err_pay = err_pay_count;
        send_frame(src, dst, sport, dport, len, csum, hdr_last);
        wait_idle(busy_at_end);

        check_equal("busy", 64'(busy_at_end), 64'd0);
        check_equal("udp_hdr_valid transfers", 64'(hdr_count - base_hdr), 64'(!hdr_last));
        if (!hdr_last) begin
            check_equal("udp_source_ip", 64'(got_src_ip), 64'(src));
            check_equal("udp_dest_ip", 64'(got_dst_ip), 64'(dst));
            check_equal("udp_source_port", 64'(got_sport), 64'(sport));
            check_equal("udp_dest_port", 64'(got_dport), 64'(dport));
            check_equal("udp_length", 64'(got_len), 64'(len));
            check_equal("udp_checksum", 64'(got_csum), 64'(csum));
        end
        check_equal("error_header_early_termination pulses",
                    64'(err_hdr_count - base_err_hdr), 64'(hdr_last));
        check_equal("error_payload_early_termination pulses",
                    64'(err_pay_count - base_err_pay), 64'(exp_early));
        check_equal("udp_payload beats", 64'(got_data.size() - base_beat),
                    64'(exp_keep.size()));

        k = 0;
        for (int b = 0; b < exp_keep.size() && base_beat + b < got_data.size(); b++) begin
            check_equal("udp_payload_tkeep", 64'(got_keep[base_beat + b]), 64'(exp_keep[b]));
            check_equal("udp_payload_tlast", 64'(got_last[base_beat + b]), 64'(exp_last[b]));
            check_equal("udp_payload_tuser", 64'(got_user[base_beat + b]), 64'(exp_user[b]));
            for (int i = 0; i < `UDP_KEEP_W; i++) begin
                if (exp_keep[b][i]) begin
                    check_equal("udp_payload_tdata", 64'(got_data[base_beat + b][8*i +: 8]),
                                64'(exp_bytes[k]));
                    k++;
                end
            end
        end
    endtask

    task automatic test_reset();
        test_errors = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal("ip_hdr_ready", 64'(ip_hdr_ready), 64'd0);
        check_equal("ip_payload_tready", 64'(ip_payload_tready), 64'd0);
        check_equal("udp_hdr_valid", 64'(udp_hdr_valid), 64'd0);
        check_equal("udp_payload_tvalid", 64'(udp_payload_tvalid), 64'd0);
        check_equal("busy", 64'(busy), 64'd0);
        check_equal("error_header_early_termination",
                    64'(error_header_early_termination), 64'd0);
        check_equal("error_payload_early_termination",
                    64'(error_payload_early_termination), 64'd0);
        // header ready one cycle after release
        @(negedge clk);
        check_equal("ip_hdr_ready", 64'(ip_hdr_ready), 64'd1);
        @(posedge clk);
        report_test("reset");
    endtask

    task automatic test_exact_frame();
        test_errors = 0;
        run_frame(16'd29, 21, 1'b0);
        run_frame(16'd24, 16, 1'b0);
        report_test("exact frame");
    endtask

    task automatic test_trimming();
        test_errors = 0;
        // 13 of 40 bytes kept, three input beats discarded
        run_frame(16'd21, 40, 1'b0);
        run_frame(16'd27, 19, 1'b0);
        report_test("trimming");
    endtask

    task automatic test_payload_early_end();
        test_errors = 0;
        run_frame(16'd38, 12, 1'b0);
        report_test("payload early termination");
    endtask

    task automatic test_header_early_end();
        test_errors = 0;
        run_frame(16'd18, 0, 1'b1);
        run_frame(16'd18, 10, 1'b0);
        report_test("header early termination");
    endtask

    task automatic test_back_pressure();
        int    nbytes;
        port_t len;
        test_errors = 0;
        bp_on <= 1'b1;
        for (int f = 0; f < 12; f++) begin
            nbytes = 1 + int'($urandom % 48);
            if ($urandom % 2 == 0) begin
                len = 16'(8 + nbytes);
            end else begin
                len = 16'(9 + int'($urandom % nbytes));
            end
            run_frame(len, nbytes, 1'b0);
        end
        bp_on <= 1'b0;
        report_test("back-pressure");
    endtask

    initial begin
        void'($urandom(32'h2e90_a36a));
        rst                = 1'b1;
        ip_hdr_valid       = 1'b0;
        ip_source_ip       = '0;
        ip_dest_ip         = '0;
        ip_payload_tdata   = '0;
        ip_payload_tkeep   = '0;
        ip_payload_tvalid  = 1'b0;
        ip_payload_tlast   = 1'b0;
        ip_payload_tuser   = 1'b0;
        udp_hdr_ready      = 1'b1;
        udp_payload_tready = 1'b1;
        bp_on              = 1'b0;
        fork
            drive_ready();
        join_none

        test_reset();
        test_exact_frame();
        test_trimming();
        test_payload_early_end();
        test_header_early_end();
        test_back_pressure();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
udp_rx_pkg.sv
axis_beat_if.sv
udp_rx_parser.sv
udp_skid_buffer.sv
udp_ip_rx.sv
tb_udp_ip_rx.sv

// ==== Makefile ====
# Verilator build and run for the udp receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_ip_rx
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
